// ==== logic/elinkPkg.sv ====
`default_nettype none

package elinkPkg;

  // Delimiter carried with every word
  typedef enum logic [1:0]
  {
    kindData = 2'b00,
    kindSof  = 2'b01,
    kindEof  = 2'b10
  } wordKindT;

  // Framed word, used at the ports and between blocks
  typedef struct packed
  {
    wordKindT   kind;
    logic [7:0] data;
  } elinkWordT;

  // One push from the dispatcher into a lane FIFO
  typedef struct packed
  {
    logic      push;
    elinkWordT word;
  } laneReqT;

  // SOF and EOF words carry no payload over the link
  localparam logic [7:0] delimData = 8'h00;

endpackage

`default_nettype wire

// ==== logic/codingPkg.sv ====
`default_nettype none

package codingPkg;

  typedef enum logic
  {
    rdNeg = 1'b0,
    rdPos = 1'b1
  } disparityT;

  // Bits in transmission order, a on bit 9 down to j on bit 0
  typedef struct packed
  {
    logic [9:0] bits;
  } symbolT;

  typedef struct packed
  {
    logic       isK;
    logic [7:0] code;
  } ctrlCodeT;

  localparam ctrlCodeT kSof   = '{isK: 1'b1, code: 8'h3C}; // K28.1
  localparam ctrlCodeT kEof   = '{isK: 1'b1, code: 8'hDC}; // K28.6
  localparam ctrlCodeT kComma = '{isK: 1'b1, code: 8'hBC}; // K28.5

  // 5b/6b abcdei at RD-, bit 6 set when inverted at RD+
  localparam logic [6:0] tbl5b6b [32] = '{
    7'b1_100111, 7'b1_011101, 7'b1_101101, 7'b0_110001,
    7'b1_110101, 7'b0_101001, 7'b0_011001, 7'b1_111000,
    7'b1_111001, 7'b0_100101, 7'b0_010101, 7'b0_110100,
    7'b0_001101, 7'b0_101100, 7'b0_011100, 7'b1_010111,
    7'b1_011011, 7'b0_100011, 7'b0_010011, 7'b0_110010,
    7'b0_001011, 7'b0_101010, 7'b0_011010, 7'b1_111010,
    7'b1_110011, 7'b0_100110, 7'b0_010110, 7'b1_110110,
    7'b0_001110, 7'b1_101110, 7'b1_011110, 7'b1_101011
  };

  // 3b/4b fghj at RD-, same flag convention
  localparam logic [4:0] tbl3b4b [8] = '{
    5'b1_1011, 5'b0_1001, 5'b0_0101, 5'b1_1100,
    5'b1_1101, 5'b0_1010, 5'b0_0110, 5'b1_1110
  };

  localparam logic [5:0] k28SixB   = 6'b001111; // K28 at RD-
  localparam logic [3:0] alt7FourB = 4'b0111;   // D.x.A7 at RD-

  // K28.5 at RD-, first symbol after reset
  localparam symbolT symCommaNeg = '{bits: 10'b0011111010};

endpackage

`default_nettype wire

// ==== logic/elinkDispatcher.sv ====
`timescale 1ns/1ps
`default_nettype none

module elinkDispatcher
  import elinkPkg::*;
#(
  parameter int Lanes     = 4,
  parameter int FifoDepth = 4
) (
  input  logic                  bitClk,
  input  logic                  rstN,
  input  elinkWordT             inWord,
  input  logic                  inValid,
  output logic                  inReady,
  output laneReqT [Lanes-1:0]   laneReq,
  input  logic    [Lanes-1:0]   creditReturn
);

  localparam int PtrW = (Lanes > 1) ? $clog2(Lanes) : 1;
  localparam int CntW = $clog2(FifoDepth + 1);

  logic [CntW-1:0] credit [Lanes];
  logic [PtrW-1:0] ptr;
  logic            accept;

  assign inReady = (credit[ptr] != '0); // Only the lane under the pointer counts
  assign accept  = inValid && inReady;

  always_comb
  begin
    for (int i = 0; i < Lanes; i++)
    begin
      laneReq[i].push = accept && (ptr == PtrW'(i));
      laneReq[i].word = inWord;
    end
  end

  always_ff @(posedge bitClk)
  begin
    if (!rstN)
    begin
      ptr <= '0;
      for (int i = 0; i < Lanes; i++)
        credit[i] <= CntW'(FifoDepth);
    end
    else
    begin
      if (accept)
        ptr <= (ptr == PtrW'(Lanes - 1)) ? '0 : ptr + 1'b1;
      for (int i = 0; i < Lanes; i++)
      begin
        // Push and return together cancel out
        case ({laneReq[i].push, creditReturn[i]})
          2'b10:   credit[i] <= credit[i] - 1'b1;
          2'b01:   credit[i] <= credit[i] + 1'b1;
          default: credit[i] <= credit[i];
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/enc8b10b.sv ====
`timescale 1ns/1ps
`default_nettype none

module enc8b10b
  import elinkPkg::*;
  import codingPkg::*;
(
  input  logic      bitClk,
  input  logic      rstN,
  input  elinkWordT word,
  input  logic      load,
  input  logic      isIdle,
  output symbolT    symbol
);

  disparityT  rd, rdMid, rdNext;
  ctrlCodeT   code;
  logic [4:0] x;
  logic [2:0] y;
  logic [5:0] six;
  logic [3:0] four;
  logic       useAlt7;
  logic [9:0] nextBits;

  always_comb
  begin
    if (isIdle)
      code = kComma;
    else
    begin
      case (word.kind)
        kindSof: code = kSof;
        kindEof: code = kEof;
        default: code = '{isK: 1'b0, code: word.data};
      endcase
    end
    x = code.code[4:0];
    y = code.code[7:5];

    if (code.isK)
      six = (rd == rdPos) ? ~k28SixB : k28SixB;
    else
      six = (tbl5b6b[x][6] && rd == rdPos) ? ~tbl5b6b[x][5:0] : tbl5b6b[x][5:0];
    rdMid = ($countones(six) != 3) ? ((rd == rdNeg) ? rdPos : rdNeg) : rd;

    // A7 avoids a run of five across the sub-blocks
    useAlt7 = !code.isK && (y == 3'd7) &&
              ((rdMid == rdNeg && (x == 5'd17 || x == 5'd18 || x == 5'd20)) ||
               (rdMid == rdPos && (x == 5'd11 || x == 5'd13 || x == 5'd14)));

    if (code.isK)
      four = (rd == rdPos) ? ~tbl3b4b[y][3:0] : tbl3b4b[y][3:0]; // K follows start RD
    else if (useAlt7)
      four = (rdMid == rdPos) ? ~alt7FourB : alt7FourB;
    else
      four = (tbl3b4b[y][4] && rdMid == rdPos) ? ~tbl3b4b[y][3:0] : tbl3b4b[y][3:0];

    nextBits = {six, four};
    rdNext   = ($countones(nextBits) != 5) ? ((rd == rdNeg) ? rdPos : rdNeg) : rd;
  end

  always_ff @(posedge bitClk)
  begin
    if (!rstN)
    begin
      symbol.bits <= ~symCommaNeg.bits; // Second comma after reset, RD+
      rd          <= rdNeg;
    end
    else if (load)
    begin
      symbol.bits <= nextBits;
      rd          <= rdNext;
    end
  end

endmodule

`default_nettype wire

// ==== logic/elinkLane.sv ====
`timescale 1ns/1ps
`default_nettype none

module elinkLane
  import elinkPkg::*;
  import codingPkg::*;
#(
  parameter int FifoDepth = 4
) (
  input  logic       bitClk,
  input  logic       rstN,
  input  laneReqT    req,
  output logic       creditReturn,
  output logic [1:0] elinkOut
);

  localparam int PtrW = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
  localparam int CntW = $clog2(FifoDepth + 1);

  elinkWordT       mem [FifoDepth];
  logic [PtrW-1:0] wrPtr;
  logic [PtrW-1:0] rdPtr;
  logic [CntW-1:0] count;
  logic [2:0]      phase;    // Pair index within the symbol
  logic [9:0]      shiftReg;
  logic            empty;
  logic            pop;
  symbolT          encSym;

  assign empty        = (count == '0);
  assign pop          = (phase == 3'd0) && !empty;
  assign creditReturn = pop;
  assign elinkOut     = shiftReg[9:8]; // Earlier bit on bit 1

  // Encoder sees the FIFO head at every boundary, comma if empty
  enc8b10b enc_i (
    .bitClk (bitClk),
    .rstN   (rstN),
    .word   (mem[rdPtr]),
    .load   (phase == 3'd0),
    .isIdle (empty),
    .symbol (encSym)
  );

  always_ff @(posedge bitClk)
  begin
    if (req.push)
      mem[wrPtr] <= req.word;
  end

  always_ff @(posedge bitClk)
  begin
    if (!rstN)
    begin
      wrPtr    <= '0;
      rdPtr    <= '0;
      count    <= '0;
      phase    <= 3'd1;              // Reset comma already under way
      shiftReg <= symCommaNeg.bits;
    end
    else
    begin
      if (req.push)
        wrPtr <= (wrPtr == PtrW'(FifoDepth - 1)) ? '0 : wrPtr + 1'b1;
      if (pop)
        rdPtr <= (rdPtr == PtrW'(FifoDepth - 1)) ? '0 : rdPtr + 1'b1;

      case ({req.push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase

      phase <= (phase == 3'd4) ? 3'd0 : phase + 1'b1;

      // Symbol from the previous boundary goes out now
      if (phase == 3'd0)
        shiftReg <= encSym.bits;
      else
        shiftReg <= {shiftReg[7:0], 2'b00};
    end
  end

endmodule

`default_nettype wire

// ==== logic/elinkCollector.sv ====
`timescale 1ns/1ps
`default_nettype none

module elinkCollector
  import elinkPkg::*;
  import codingPkg::*;
#(
  parameter int Lanes = 4
) (
  input  logic                  bitClk,
  input  logic                  rstN,
  input  logic [Lanes-1:0][1:0] elinkIn,
  output elinkWordT             outWord,
  output logic                  outValid,
  output logic                  linkUp
);

  localparam int PtrW = (Lanes > 1) ? $clog2(Lanes) : 1;

  typedef enum logic [1:0] {alHunt, alCand, alLocked} alignStateT;

  typedef struct packed
  {
    logic      ok;
    elinkWordT word;
  } decodeT;

  alignStateT      alState   [Lanes];
  logic [7:0]      win       [Lanes];
  logic [2:0]      cnt       [Lanes];
  logic [2:0]      markPhase [Lanes]; // Candidate offset, then locked offset
  logic [9:0]      curr      [Lanes];
  decodeT          dec       [Lanes];
  elinkWordT       slot      [Lanes];
  logic [Lanes-1:0] commaHit, lockedVec, newValid, slotFull;
  logic [PtrW-1:0] rrPtr;
  logic            emitSlot;
  logic            emitNew;

  // Reverse table lookup, commas give ok low
  function automatic decodeT decodeSym(input logic [9:0] s);
    decodeT     d;
    logic [5:0] six;
    logic [3:0] four;
    logic [3:0] fk;
    logic       hit6;
    logic       hit4;
    d    = '{ok: 1'b0, word: '{kind: kindData, data: 8'h00}};
    six  = s[9:4];
    four = s[3:0];
    hit6 = 1'b0;
    hit4 = 1'b0;
    if (six == k28SixB || six == ~k28SixB)
    begin
      fk = (six == k28SixB) ? four : ~four;
      if (fk == tbl3b4b[1][3:0])
        d = '{ok: 1'b1, word: '{kind: kindSof, data: delimData}};
      else if (fk == tbl3b4b[6][3:0])
        d = '{ok: 1'b1, word: '{kind: kindEof, data: delimData}};
    end
    else
    begin
      for (int x = 0; x < 32; x++)
        if (six == tbl5b6b[x][5:0] || (tbl5b6b[x][6] && six == ~tbl5b6b[x][5:0]))
        begin
          d.word.data[4:0] = 5'(x);
          hit6 = 1'b1;
        end
      for (int y = 0; y < 8; y++)
        if (four == tbl3b4b[y][3:0] || (tbl3b4b[y][4] && four == ~tbl3b4b[y][3:0]))
        begin
          d.word.data[7:5] = 3'(y);
          hit4 = 1'b1;
        end
      if (four == alt7FourB || four == ~alt7FourB)
      begin
        d.word.data[7:5] = 3'd7;
        hit4 = 1'b1;
      end
      d.ok = hit6 && hit4; // Unknown symbols are dropped
    end
    return d;
  endfunction

  always_comb
  begin
    for (int i = 0; i < Lanes; i++)
    begin
      curr[i]      = {win[i], elinkIn[i]}; // Includes the pair arriving now
      commaHit[i]  = (curr[i] == symCommaNeg.bits) || (curr[i] == ~symCommaNeg.bits);
      lockedVec[i] = (alState[i] == alLocked);
      dec[i]       = decodeSym(curr[i]);
      newValid[i]  = lockedVec[i] && (cnt[i] == markPhase[i]) && dec[i].ok;
    end
    emitSlot = slotFull[rrPtr];
    emitNew  = !emitSlot && newValid[rrPtr];
  end

  always_ff @(posedge bitClk)
  begin
    if (!rstN)
    begin
      for (int i = 0; i < Lanes; i++)
      begin
        alState[i]   <= alHunt;
        win[i]       <= '0;
        cnt[i]       <= 3'd0;
        markPhase[i] <= 3'd0;
      end
      slotFull <= '0;
      rrPtr    <= '0;
      outValid <= 1'b0;
      linkUp   <= 1'b0;
    end
    else
    begin
      for (int i = 0; i < Lanes; i++)
      begin
        win[i] <= curr[i][7:0];
        cnt[i] <= (cnt[i] == 3'd4) ? 3'd0 : cnt[i] + 1'b1;
        case (alState[i])
          alHunt:
            if (commaHit[i])
            begin
              alState[i]   <= alCand;
              markPhase[i] <= cnt[i];
            end
          alCand:
            if (commaHit[i])
            begin
              if (cnt[i] == markPhase[i])
                alState[i] <= alLocked; // Same offset twice
              else
                markPhase[i] <= cnt[i];
            end
          default: ;
        endcase

        // Lanes ahead of the pointer park their word
        if (newValid[i] && !(emitNew && rrPtr == PtrW'(i)))
          slotFull[i] <= 1'b1;
        else if (emitSlot && rrPtr == PtrW'(i))
          slotFull[i] <= 1'b0;
      end

      outValid <= emitSlot || emitNew;
      if (emitSlot || emitNew)
        rrPtr <= (rrPtr == PtrW'(Lanes - 1)) ? '0 : rrPtr + 1'b1;
      linkUp <= linkUp || (&lockedVec); // Sticky
    end
  end

  always_ff @(posedge bitClk)
  begin
    outWord <= emitSlot ? slot[rrPtr] : dec[rrPtr].word;
    for (int i = 0; i < Lanes; i++)
      if (newValid[i])
        slot[i] <= dec[i].word;
  end

endmodule

`default_nettype wire

// ==== logic/elinkTxTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module elinkTxTop
  import elinkPkg::*;
#(
  parameter int Lanes     = 4,
  parameter int FifoDepth = 4
) (
  input  logic                  bitClk,
  input  logic                  rstN,
  input  elinkWordT             inWord,
  input  logic                  inValid,
  output logic                  inReady,
  output elinkWordT             outWord,
  output logic                  outValid,
  output logic                  linkUp,
  output logic [Lanes-1:0][1:0] elinkOut
);

  laneReqT [Lanes-1:0] laneReq;
  logic    [Lanes-1:0] creditReturn;

  elinkDispatcher #(
    .Lanes     (Lanes),
    .FifoDepth (FifoDepth)
  ) dispatcher_i (
    .bitClk       (bitClk),
    .rstN         (rstN),
    .inWord       (inWord),
    .inValid      (inValid),
    .inReady      (inReady),
    .laneReq      (laneReq),
    .creditReturn (creditReturn)
  );

  for (genvar i = 0; i < Lanes; i++)
  begin : gLane
    elinkLane #(
      .FifoDepth (FifoDepth)
    ) lane_i (
      .bitClk       (bitClk),
      .rstN         (rstN),
      .req          (laneReq[i]),
      .creditReturn (creditReturn[i]),
      .elinkOut     (elinkOut[i])
    );
  end

  // Receive check taps the same pairs that leave the chip
  elinkCollector #(
    .Lanes (Lanes)
  ) collector_i (
    .bitClk   (bitClk),
    .rstN     (rstN),
    .elinkIn  (elinkOut),
    .outWord  (outWord),
    .outValid (outValid),
    .linkUp   (linkUp)
  );

endmodule

`default_nettype wire

// ==== tests/elinkDispatcher_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module creditChecker
  import elinkPkg::*;
#(
  parameter int Lanes     = 4,
  parameter int FifoDepth = 4,
  parameter int PtrW      = 2,
  parameter int CntW      = 3
) (
  input logic                bitClk,
  input logic                rstN,
  input logic                inReady,
  input laneReqT [Lanes-1:0] laneReq,
  input logic [Lanes-1:0]    creditReturn,
  input logic [CntW-1:0]     credit [Lanes],
  input logic [PtrW-1:0]     ptr
);

  int shadowCredit [Lanes]; // Rebuilt from pushes and returns only

  always_ff @(posedge bitClk)
  begin
    if (!rstN)
    begin
      for (int i = 0; i < Lanes; i++)
        shadowCredit[i] <= FifoDepth;
    end
    else
    begin
      for (int i = 0; i < Lanes; i++)
        shadowCredit[i] <= shadowCredit[i] - int'(laneReq[i].push) + int'(creditReturn[i]);
    end
  end

  for (genvar i = 0; i < Lanes; i++)
  begin : gLane
    // A push spends one credit, so one must be there
    pushNeedsCredit: assert property (
      @(posedge bitClk) disable iff (!rstN)
      laneReq[i].push |-> (shadowCredit[i] > 0)
    ) else $error("lane %0d pushed with zero credit", i);

    creditBounded: assert property (
      @(posedge bitClk) disable iff (!rstN)
      credit[i] <= CntW'(FifoDepth) // Never more than the FIFO holds
    ) else $error("lane %0d credit above the FIFO depth", i);
  end

  readyWithCredit: assert property (
    @(posedge bitClk) disable iff (!rstN)
    (shadowCredit[ptr] > 0) |-> inReady
  ) else $error("inReady low while the current lane has credit");

endmodule

`default_nettype wire

// ==== tests/elinkTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module elinkTb
  import elinkPkg::*;
();

  localparam int Lanes        = 4;
  localparam int FifoDepth    = 4;
  localparam int GappedWords  = 16; // Words sent with random gaps, the rest is one burst
  localparam int BalanceLimit = 6;
  localparam int TestCount    = 6;

  logic                  bitClk;
  logic                  rstN;
  elinkWordT             inWord;
  logic                  inValid;
  logic                  inReady;
  elinkWordT             outWord;
  logic                  outValid;
  logic                  linkUp;
  logic [Lanes-1:0][1:0] elinkOut;

  elinkWordT golden [$];
  int        seed        = 48753;
  int        cycles      = 0;
  int        cycleLimit  = 0;
  int        expIdx      = 0;
  int        readyLows   = 0;
  int        failedTests = 0;
  int        dcSum [Lanes] = '{default: 0};
  logic      running     = 1'b0;
  logic      linkSeen    = 1'b0;
  logic      verdictDone = 1'b0;
  int        errReset    = 0;
  int        errLink     = 0;
  int        errData     = 0;
  int        errDelim    = 0;
  int        errBurst    = 0;
  int        errBalance  = 0;

  elinkTxTop #(
    .Lanes     (Lanes),
    .FifoDepth (FifoDepth)
  ) elinkTxTop_i (
    .bitClk   (bitClk),
    .rstN     (rstN),
    .inWord   (inWord),
    .inValid  (inValid),
    .inReady  (inReady),
    .outWord  (outWord),
    .outValid (outValid),
    .linkUp   (linkUp),
    .elinkOut (elinkOut)
  );

  // Credit rules watched inside the dispatcher
  bind elinkDispatcher creditChecker #(
    .Lanes     (Lanes),
    .FifoDepth (FifoDepth),
    .PtrW      (PtrW),
    .CntW      (CntW)
  ) creditChecker_i (
    .bitClk       (bitClk),
    .rstN         (rstN),
    .inReady      (inReady),
    .laneReq      (laneReq),
    .creditReturn (creditReturn),
    .credit       (credit),
    .ptr          (ptr)
  );

  initial
  begin
    bitClk = 1'b0;
    forever #50 bitClk = ~bitClk;
  end

  task automatic checkWord(input string name, input elinkWordT exp, input elinkWordT act,
                           inout int errs);
    if (act !== exp)
    begin
      $display("mismatch %s expected kind %0d byte %02h actual kind %0d byte %02h",
               name, exp.kind, exp.data, act.kind, act.data);
      errs++;
    end
  endtask

  task automatic checkFlag(input string name, input logic exp, input logic act,
                           inout int errs);
    if (act !== exp)
    begin
      $display("mismatch %s expected %b actual %b", name, exp, act);
      errs++;
    end
  endtask

  task automatic checkBalance(input string name, input int lane, input int sum,
                              inout int errs);
    if (sum > BalanceLimit || sum < -BalanceLimit)
    begin
      $display("mismatch %s lane %0d expected -%0d to %0d actual %0d",
               name, lane, BalanceLimit, BalanceLimit, sum);
      errs++;
    end
  endtask

  task automatic reportTest(input string name, input int errs);
    if (errs != 0)
      failedTests++;
    $display("test %s %s with %0d errors", name, (errs == 0) ? "passed" : "failed", errs);
  endtask

  // Two hex columns per line, kind then byte
  task automatic loadGolden();
    int        fd;
    int        k;
    int        b;
    string     line;
    elinkWordT w;
    fd = $fopen("tests/elinkGolden.txt", "r");
    if (fd == 0)
      $display("cannot open tests/elinkGolden.txt");
    else
    begin
      while ($fgets(line, fd) != 0)
      begin
        if ($sscanf(line, "%h %h", k, b) == 2)
        begin
          w.kind = wordKindT'(k[1:0]);
          w.data = b[7:0];
          golden.push_back(w);
        end
      end
      $fclose(fd);
    end
  endtask

  // Called on a falling edge, returns on the falling edge after the transfer
  task automatic sendWord(input elinkWordT w, input logic inBurst);
    inWord  = w;
    inValid = 1'b1;
    while (!inReady)
    begin
      if (inBurst)
        readyLows++;
      @(negedge bitClk);
    end
    @(negedge bitClk);
  endtask

  always @(posedge bitClk)
  begin
    running <= rstN;
    cycles  <= cycles + 1;
    if (cycleLimit > 0 && cycles >= cycleLimit)
    begin
      $display("timeout after %0d cycles, only %0d of %0d words came out",
               cycles, expIdx, golden.size());
      verdictDone = 1'b1;
      $display("** FAIL **");
      $finish;
    end
  end

  // Output side, sampled on the falling edge
  always @(negedge bitClk)
  begin
    if (running)
    begin
      for (int i = 0; i < Lanes; i++)
      begin
        dcSum[i] += (elinkOut[i][1] ? 1 : -1) + (elinkOut[i][0] ? 1 : -1);
        checkBalance("balance", i, dcSum[i], errBalance);
      end
      if (outValid || linkSeen)
        checkFlag("linkUp", 1'b1, linkUp, errLink); // Up before data, then sticky
      linkSeen = linkSeen || linkUp;
      if (outValid)
      begin
        if (expIdx >= golden.size())
        begin
          $display("the DUT delivered a word beyond the end of the golden data");
          errData++;
        end
        else
        begin
          checkWord("data", golden[expIdx], outWord, errData);
          if (golden[expIdx].kind != kindData || outWord.kind != kindData)
            checkWord("delimiters", golden[expIdx], outWord, errDelim);
          expIdx++;
        end
      end
    end
  end

  initial
  begin
    int gap;
    rstN    = 1'b0;
    inValid = 1'b0;
    inWord  = '{kind: kindData, data: 8'h00};
    loadGolden();
    if (golden.size() == 0)
    begin
      $display("no stimulus, the golden file is missing or empty");
      errData++;
    end
    cycleLimit = 200 + 10 * golden.size();

    repeat (16)
    begin
      @(negedge bitClk);
      checkFlag("reset outValid", 1'b0, outValid, errReset);
      checkFlag("reset linkUp", 1'b0, linkUp, errReset);
      checkFlag("reset inReady", 1'b1, inReady, errReset);
    end
    rstN = 1'b1;
    @(negedge bitClk);
    checkFlag("reset outValid", 1'b0, outValid, errReset);
    checkFlag("reset linkUp", 1'b0, linkUp, errReset);
    checkFlag("reset inReady", 1'b1, inReady, errReset);
    reportTest("reset", errReset);

    // Words sent before lock would be lost during alignment
    while (!linkUp)
      @(negedge bitClk);

    for (int n = 0; n < golden.size(); n++)
    begin
      if (n < GappedWords)
      begin
        gap     = $unsigned($random(seed)) % 5;
        inValid = 1'b0;
        repeat (gap)
          @(negedge bitClk);
        sendWord(golden[n], 1'b0);
      end
      else
        sendWord(golden[n], 1'b1); // inValid stays high across the burst
    end
    inValid = 1'b0;

    while (expIdx < golden.size())
      @(negedge bitClk);
    repeat (20)
      @(negedge bitClk); // Catch a stray extra word

    if (readyLows == 0)
    begin
      $display("inReady never fell during the burst section");
      errBurst++;
    end
    reportTest("linkUp", errLink);
    reportTest("data", errData);
    reportTest("delimiters", errDelim);
    reportTest("backpressure", errBurst);
    reportTest("balance", errBalance);

    $display("%0d tests, %0d failed, %0d words checked, %0d cycles with inReady low",
             TestCount, failedTests, expIdx, readyLows);
    verdictDone = 1'b1;
    if (failedTests == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

  // Run stopped early by a failed assertion
  final
  begin
    if (!verdictDone)
      $display("** FAIL **");
  end

endmodule

`default_nettype wire

// ==== tests/elinkGolden.txt ====
// kind (0 data, 1 sof, 2 eof) then byte, both hex, one word per line
// SOF and EOF carry byte 00, words are expected back in this order
1 00
0 a5
0 3c
0 00
0 ff
0 17
0 f1
2 00
1 00
0 5a
0 eb
0 7e
0 81
0 c3
0 bc
2 00
1 00
0 10
0 11
0 12
0 13
0 14
0 15
0 16
0 17
0 18
0 19
0 1a
0 1b
2 00
1 00
0 20
0 31
0 42
0 53
0 64
0 75
0 86
0 97
0 a8
0 b9
0 ca
0 db
2 00
1 00
0 e0
0 e1
0 e2
0 e3
0 e4
0 e5
0 e6
0 e7
0 e8
0 e9
0 ea
0 eb
2 00
1 00
0 ec
0 ed
0 ee
0 ef
0 f0
0 f1
0 f2
0 f3
0 f4
0 f5
0 f6
0 f7
2 00
1 00
0 f8
0 f9
0 fa
0 fb
0 fc
0 fd
0 fe
0 ff
0 01
0 02
0 04
0 08
2 00
1 00
0 80
0 40
0 20
0 10
0 c0
0 60
0 30
0 18
0 0c
0 06
0 03
0 55
2 00
1 00
0 aa
0 99
0 66
0 33
0 cc
0 77
0 88
0 de
0 ad
0 be
0 ef
0 42
2 00
1 00
0 69
0 96
0 5c
0 c5
0 7c
0 47
0 9e
0 e9
0 1f
0 2f
0 2e
0 e2
2 00

// ==== verilog.f ====
logic/elinkPkg.sv
logic/codingPkg.sv
logic/elinkDispatcher.sv
logic/enc8b10b.sv
logic/elinkLane.sv
logic/elinkCollector.sv
logic/elinkTxTop.sv
tests/elinkDispatcher_properties.sv
tests/elinkTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the E-link testbench with Verilator, run from the project root
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module elinkTb \
  -o elinkSim && ./obj_dir/elinkSim > sim.log 2>&1 || echo "simulation did not complete"
cat sim.log 2>/dev/null
grep -F -q '** PASS **' sim.log && echo "run passed" || { echo "run failed"; exit 1; }
